// File: Bender.yml
package:
  name: rv_pipe

export_include_dirs:
  - common

sources:
  - files:
      - common/rv_pipe_pkg.sv
      - hw/fetch_stage.sv
      - hw/decode/reg_file.sv
      - hw/decode/decode_stage.sv
      - hw/execute/execute_stage.sv
      - hw/rv_pipe.sv
  - target: test
    files:
      - testbench/rv_pipe_chk.sv
      - testbench/rv_pipe_tb.sv

// File: common/rv_pipe_defs.svh
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define XLEN       32             // data and address width
`define INST_W     32             // instruction word
`define REG_IDX_W  5              // x0..x31

////////////////////////////////////////
// fixed values
////////////////////////////////////////

// first fetch address out of reset
`define RESET_PC   32'h0000_0000

// addi x0, x0, 0
`define NOP_INST   32'h0000_0013  // bubble filler

`endif

// File: common/rv_pipe_pkg.sv
`include "rv_pipe_defs.svh"

package rv_pipe_pkg;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // reg-reg alu
        OPC_OP_IMM = 7'b0010011,  // reg-imm alu
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011   // beq / bne only
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                  // signed compare
        ALU_PASS_B                // lui
    } alu_op_e;

    ////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`INST_W-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        logic [`REG_IDX_W-1:0] rs1_idx;
        logic [`REG_IDX_W-1:0] rs2_idx;
        logic                  rs1_used;   // source really read
        logic                  rs2_used;
        logic [`XLEN-1:0]      rs1_value;  // from regfile, pre-forward
        logic [`XLEN-1:0]      rs2_value;
        logic [`XLEN-1:0]      imm;
        logic                  use_imm;    // operand b is imm
        alu_op_e               alu_op;
        logic                  is_branch;
        logic                  branch_ne;  // bne, else beq
        logic [`REG_IDX_W-1:0] rd_idx;
        logic                  wr_en;
    } id_ex_t;

    // also the writeback bus and commit record
    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        logic [`REG_IDX_W-1:0] rd_idx;
        logic                  wr_en;      // never set for x0
        logic [`XLEN-1:0]      result;
    } ex_wb_t;

endpackage

// File: hw/decode/decode_stage.sv
`include "rv_pipe_defs.svh"

module decode_stage import rv_pipe_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  if_id_t if_id,
    input  logic   redirect,      // flush what is in IF/ID
    input  ex_wb_t wb,            // writeback port, to regfile
    output id_ex_t id_ex
);

    logic [`INST_W-1:0]    inst;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`XLEN-1:0]      imm_i;
    logic [`XLEN-1:0]      imm_u;
    logic [`XLEN-1:0]      imm_b;
    logic [`XLEN-1:0]      rs1_value;
    logic [`XLEN-1:0]      rs2_value;
    id_ex_t                id_next;

    ////////////////////////////////////////
    // fields and immediates
    ////////////////////////////////////////

    assign inst    = if_id.inst;
    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    reg_file reg_file0 (
        .clock     (clock),
        .reset     (reset),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .wb        (wb),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    ////////////////////////////////////////
    // control decode
    ////////////////////////////////////////

    always_comb begin
        id_next           = '0;
        id_next.valid     = if_id.valid;
        id_next.pc        = if_id.pc;
        id_next.rs1_idx   = rs1_idx;
        id_next.rs2_idx   = rs2_idx;
        id_next.rs1_value = rs1_value;
        id_next.rs2_value = rs2_value;
        id_next.rd_idx    = inst[11:7];
        id_next.imm       = imm_i;      // i-type unless told otherwise
        id_next.alu_op    = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                id_next.rs1_used = 1'b1;
                id_next.rs2_used = 1'b1;
                id_next.wr_en    = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: id_next.alu_op = ALU_ADD;
                    10'b0100000_000: id_next.alu_op = ALU_SUB;
                    10'b0000000_111: id_next.alu_op = ALU_AND;
                    10'b0000000_110: id_next.alu_op = ALU_OR;
                    10'b0000000_100: id_next.alu_op = ALU_XOR;
                    10'b0000000_010: id_next.alu_op = ALU_SLT;
                    default:         id_next.wr_en  = 1'b0;  // shifts etc, no-op
                endcase
            end
            OPC_OP_IMM: begin
                id_next.rs1_used = 1'b1;
                id_next.use_imm  = 1'b1;
                id_next.wr_en    = 1'b1;
                case (funct3)
                    3'b000:  id_next.alu_op = ALU_ADD;
                    3'b111:  id_next.alu_op = ALU_AND;
                    3'b110:  id_next.alu_op = ALU_OR;
                    3'b100:  id_next.alu_op = ALU_XOR;
                    default: id_next.wr_en  = 1'b0;   // slti/shifts dropped
                endcase
            end
            OPC_LUI: begin
                id_next.imm     = imm_u;
                id_next.use_imm = 1'b1;
                id_next.alu_op  = ALU_PASS_B;
                id_next.wr_en   = 1'b1;
            end
            OPC_BRANCH: begin
                id_next.rs1_used  = 1'b1;
                id_next.rs2_used  = 1'b1;
                id_next.imm       = imm_b;
                id_next.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                id_next.branch_ne = (funct3 == 3'b001);
            end
            default: ;                      // unknown opcode, commits as no-op
        endcase
        // bubble on flush or empty slot
        if (redirect || !if_id.valid) begin
            id_next.valid     = 1'b0;
            id_next.wr_en     = 1'b0;
            id_next.is_branch = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        id_ex <= id_next;
        if (reset) begin
            id_ex.valid     <= 1'b0;
            id_ex.wr_en     <= 1'b0;
            id_ex.is_branch <= 1'b0;
        end
    end

endmodule

// File: hw/decode/reg_file.sv
`include "rv_pipe_defs.svh"

module reg_file import rv_pipe_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`REG_IDX_W-1:0] rs1_idx,
    input  logic [`REG_IDX_W-1:0] rs2_idx,
    input  ex_wb_t                wb,
    output logic [`XLEN-1:0]      rs1_value,
    output logic [`XLEN-1:0]      rs2_value
);

    logic [`XLEN-1:0] regs [1:31];  // x0 has no storage
    logic             wr_fire;

    assign wr_fire = wb.valid && wb.wr_en && (wb.rd_idx != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire) begin
            regs[wb.rd_idx] <= wb.result;
        end
    end

    // x0 reads zero, same-cycle write seen at once
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_fire && (idx == wb.rd_idx)) begin
            return wb.result;               // covers the two-ahead dependence
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_value = read_port(rs1_idx);
        rs2_value = read_port(rs2_idx);
    end

endmodule

// File: hw/execute/execute_stage.sv
`include "rv_pipe_defs.svh"

module execute_stage import rv_pipe_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  id_ex_t           id_ex,
    output logic             redirect,     // taken branch, flush younger
    output logic [`XLEN-1:0] redirect_pc,
    output ex_wb_t           ex_wb
);

    logic             fwd_rs1;
    logic             fwd_rs2;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;            // forwarded rs2, for compare
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic             taken;
    ex_wb_t           ex_next;

    ////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////

    // only the instruction just ahead, older ones come through the regfile
    assign fwd_rs1 = ex_wb.valid && ex_wb.wr_en && (ex_wb.rd_idx != '0)
                     && id_ex.rs1_used && (ex_wb.rd_idx == id_ex.rs1_idx);
    assign fwd_rs2 = ex_wb.valid && ex_wb.wr_en && (ex_wb.rd_idx != '0)
                     && id_ex.rs2_used && (ex_wb.rd_idx == id_ex.rs2_idx);

    assign op_a    = fwd_rs1 ? ex_wb.result : id_ex.rs1_value;
    assign rs2_val = fwd_rs2 ? ex_wb.result : id_ex.rs2_value;
    assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_val;

    ////////////////////////////////////////
    // alu and branch
    ////////////////////////////////////////

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;    // lui
            default:    alu_result = '0;
        endcase
    end

    assign taken       = (op_a == rs2_val) ^ id_ex.branch_ne;   // beq, inverted for bne
    assign redirect    = id_ex.valid && id_ex.is_branch && taken;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    ////////////////////////////////////////
    // EX/WB register
    ////////////////////////////////////////

    always_comb begin
        ex_next.valid  = id_ex.valid;
        ex_next.pc     = id_ex.pc;
        ex_next.rd_idx = id_ex.rd_idx;
        ex_next.wr_en  = id_ex.valid && id_ex.wr_en && (id_ex.rd_idx != '0);  // x0 drops
        ex_next.result = alu_result;
    end

    always_ff @(posedge clock) begin
        ex_wb <= ex_next;
        if (reset) begin
            ex_wb.valid <= 1'b0;
            ex_wb.wr_en <= 1'b0;
        end
    end

endmodule

// File: hw/fetch_stage.sv
`include "rv_pipe_defs.svh"

module fetch_stage import rv_pipe_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic [`INST_W-1:0] imem_data,   // same-cycle read data
    input  logic               redirect,    // taken branch in execute
    input  logic [`XLEN-1:0]   redirect_pc,
    output logic [`XLEN-1:0]   imem_addr,
    output if_id_t             if_id
);

    logic [`XLEN-1:0] pc;
    if_id_t           if_next;

    ////////////////////////////////////////
    // program counter
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;          // branch target wins
        end else begin
            pc <= pc + `XLEN'd4;        // one word per cycle, no stall
        end
    end

    assign imem_addr = pc;

    ////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////

    always_comb begin
        if_next.valid = 1'b1;
        if_next.pc    = pc;
        if_next.inst  = imem_data;
        // word on the wrong path, drop it
        if (redirect) begin
            if_next.valid = 1'b0;
            if_next.inst  = `NOP_INST;
        end
    end

    always_ff @(posedge clock) begin
        if_id <= if_next;               // payload loads every cycle
        if (reset) begin
            if_id.valid <= 1'b0;
        end
    end

endmodule

// File: hw/rv_pipe.sv
`include "rv_pipe_defs.svh"

module rv_pipe import rv_pipe_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic [`INST_W-1:0] imem_data,
    output logic [`XLEN-1:0]   imem_addr,
    output ex_wb_t             commit      // one record per retired instruction
);

    if_id_t           if_id;
    id_ex_t           id_ex;
    ex_wb_t           ex_wb;           // writeback bus as well
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;

    fetch_stage fetch_stage0 (
        .clock       (clock),
        .reset       (reset),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .if_id       (if_id)
    );

    decode_stage decode_stage0 (
        .clock    (clock),
        .reset    (reset),
        .if_id    (if_id),
        .redirect (redirect),
        .wb       (ex_wb),             // loops back to the regfile
        .id_ex    (id_ex)
    );

    execute_stage execute_stage0 (
        .clock       (clock),
        .reset       (reset),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_wb       (ex_wb)
    );

    assign commit = ex_wb;

endmodule

// File: rv_pipe.f
+incdir+common
common/rv_pipe_pkg.sv
hw/fetch_stage.sv
hw/decode/reg_file.sv
hw/decode/decode_stage.sv
hw/execute/execute_stage.sv
hw/rv_pipe.sv
testbench/rv_pipe_chk.sv
testbench/rv_pipe_tb.sv

// File: testbench/rv_pipe_chk.sv
`include "rv_pipe_defs.svh"

module rv_pipe_chk import rv_pipe_pkg::*; (
    input logic   clock,
    input logic   reset,
    input logic   redirect,
    input ex_wb_t ex_wb
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assert_fails = 0;

    ////////////////////////////////////////
    // execute stage properties
    ////////////////////////////////////////

    // pipeline comes out of reset empty
    quiet_after_reset: assert property (@(posedge clock) reset |=> !ex_wb.valid)
        else begin
            $error("ex_wb valid in the cycle after reset");
            assert_fails++;
        end

    no_x0_write: assert property (@(posedge clock) disable iff (reset)
        ex_wb.wr_en |-> (ex_wb.rd_idx != '0))
        else begin
            $error("ex_wb write enable set for x0");
            assert_fails++;
        end

    // branch itself retires, then two flushed slots
    flush_after_redirect: assert property (@(posedge clock) disable iff (reset)
        redirect |=> ex_wb.valid ##1 !ex_wb.valid ##1 !ex_wb.valid)
        else begin
            $error("younger instruction reached ex_wb after a taken branch");
            assert_fails++;
        end

endmodule

bind execute_stage rv_pipe_chk chk0 (
    .clock    (clock),
    .reset    (reset),
    .redirect (redirect),
    .ex_wb    (ex_wb)
);

// File: testbench/rv_pipe_tb.sv
`include "rv_pipe_defs.svh"

module rv_pipe_tb import rv_pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 6;
    localparam int CODE_SIZE = 128;

    logic               clock;
    logic               reset;
    logic [`INST_W-1:0] imem_data;
    logic [`XLEN-1:0]   imem_addr;
    ex_wb_t             commit;

    logic [`INST_W-1:0] code [0:CODE_SIZE-1];   // all programs back to back
    int                 test_base [0:NUM_TESTS-1];
    int                 test_len  [0:NUM_TESTS-1];
    string              test_name [0:NUM_TESTS-1];
    int                 fill = 0;
    int                 num_built = 0;
    int                 cur_test = 0;
    int                 cur_base = 0;
    int                 cur_len = 0;
    ex_wb_t             expected [$];           // model commits, program order
    logic               active = 1'b0;
    logic               test_done = 1'b0;
    int                 test_errors = 0;
    int                 error_count = 0;
    int                 checked = 0;
    int                 total_checked = 0;
    int                 cycle_count = 0;
    int                 cycle_limit = 0;

    rv_pipe dut0 (
        .clock     (clock),
        .reset     (reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .commit    (commit)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;                 // 8 ns period
    end

    // instruction memory, same-cycle read
    always_comb begin
        imem_data = `NOP_INST;                     // past the end of the program
        if ((imem_addr >> 2) < cur_len) begin
            imem_data = code[cur_base + (imem_addr >> 2)];
        end
    end

    ////////////////////////////////////////
    // encoders and program build
    ////////////////////////////////////////

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [2:0] f3, input int rd, input int rs1,
                                          input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] utype(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] btype(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        code[fill] = word;
        fill++;
    endtask

    task automatic start_program(input string name);
        test_base[num_built] = fill;
        test_name[num_built] = name;
    endtask

    task automatic close_program();
        test_len[num_built] = fill - test_base[num_built];
        num_built++;
    endtask

    task automatic build_programs();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int imm;
        start_program("alu_imm");
        emit(itype(3'b000, 1, 0, 'h123));          // addi x1, x0, 0x123
        emit(itype(3'b000, 2, 0, -5));
        emit(utype(3, 'habcde));                   // lui x3
        emit(itype(3'b100, 4, 0, 'h5a5));          // xori
        emit(itype(3'b110, 5, 0, 'h0f0));          // ori
        emit(itype(3'b111, 6, 2, 'h7f0));          // andi
        emit(rtype(7'h00, 3'b000, 7, 1, 2));       // add
        emit(rtype(7'h20, 3'b000, 8, 3, 1));       // sub
        emit(rtype(7'h00, 3'b111, 9, 4, 2));       // and
        emit(rtype(7'h00, 3'b110, 10, 5, 1));      // or
        emit(rtype(7'h00, 3'b100, 11, 3, 4));      // xor
        emit(rtype(7'h00, 3'b010, 12, 2, 1));      // slt, negative vs positive
        close_program();
        start_program("fwd_exwb");
        emit(itype(3'b000, 1, 0, 7));
        emit(itype(3'b000, 1, 1, 3));              // x1 from the one just ahead
        emit(rtype(7'h00, 3'b000, 2, 1, 1));
        emit(rtype(7'h20, 3'b000, 3, 2, 1));
        emit(utype(4, 'h80000));
        emit(rtype(7'h00, 3'b010, 5, 4, 3));
        close_program();
        start_program("regfile_bypass");
        emit(itype(3'b000, 1, 0, 100));
        emit(itype(3'b000, 2, 0, -1));
        emit(rtype(7'h00, 3'b000, 3, 1, 0));       // x1 two ahead
        emit(rtype(7'h00, 3'b111, 4, 2, 1));
        emit(itype(3'b000, 5, 0, 1));
        emit(itype(3'b000, 5, 0, 2));
        emit(rtype(7'h00, 3'b000, 6, 5, 5));       // newest x5 must win
        close_program();
        start_program("branch");
        emit(itype(3'b000, 1, 0, 5));
        emit(itype(3'b000, 2, 0, 5));
        emit(btype(3'b000, 1, 2, 12));             // beq taken
        emit(itype(3'b000, 3, 0, 'h33));           // wrong path
        emit(itype(3'b000, 4, 0, 'h44));           // wrong path
        emit(btype(3'b001, 1, 2, 12));             // bne not taken
        emit(itype(3'b000, 5, 0, 1));
        emit(btype(3'b001, 5, 0, 12));             // bne taken, x5 forwarded
        emit(itype(3'b000, 6, 0, 'h66));
        emit(itype(3'b000, 7, 0, 'h77));
        emit(btype(3'b000, 5, 1, 8));              // beq not taken
        emit(rtype(7'h00, 3'b000, 8, 1, 5));
        close_program();
        start_program("x0_nop");
        emit(itype(3'b000, 0, 0, 'h55));
        emit(utype(0, 'h12345));
        emit(rtype(7'h00, 3'b000, 1, 0, 0));       // x0 still reads zero
        emit(itype(3'b000, 2, 0, 3));
        emit(rtype(7'h00, 3'b001, 3, 2, 2));       // sll, outside the subset
        emit(32'hffff_ffff);                       // unknown opcode
        emit(rtype(7'h00, 3'b110, 4, 3, 2));
        close_program();
        start_program("random");
        for (int i = 0; i < 40; i++) begin
            kind = $urandom_range(10, 0);
            rd   = $urandom_range(7, 0);           // few registers, many hazards
            rs1  = $urandom_range(7, 0);
            rs2  = $urandom_range(7, 0);
            imm  = $urandom;
            case (kind)
                0:       emit(rtype(7'h00, 3'b000, rd, rs1, rs2));
                1:       emit(rtype(7'h20, 3'b000, rd, rs1, rs2));
                2:       emit(rtype(7'h00, 3'b111, rd, rs1, rs2));
                3:       emit(rtype(7'h00, 3'b110, rd, rs1, rs2));
                4:       emit(rtype(7'h00, 3'b100, rd, rs1, rs2));
                5:       emit(rtype(7'h00, 3'b010, rd, rs1, rs2));
                6:       emit(itype(3'b000, rd, rs1, imm));
                7:       emit(itype(3'b111, rd, rs1, imm));
                8:       emit(itype(3'b110, rd, rs1, imm));
                9:       emit(itype(3'b100, rd, rs1, imm));
                default: emit(utype(rd, imm));
            endcase
        end
        close_program();
    endtask

    ////////////////////////////////////////
    // instruction-set model
    ////////////////////////////////////////

    function automatic void model_program(input int base, input int len);
        logic [31:0] x [0:31];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic        take;
        ex_wb_t      rec;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc    = `RESET_PC;
        steps = 0;
        expected.delete();
        while ((pc >> 2) < len && steps < CODE_SIZE) begin
            inst  = code[base + (pc >> 2)];
            a     = x[inst[19:15]];
            b     = x[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            take  = 1'b0;
            rec        = '0;
            rec.valid  = 1'b1;
            rec.pc     = pc;
            rec.rd_idx = inst[11:7];
            rec.wr_en  = 1'b1;
            case (inst[6:0])
                7'b0110011: begin
                    case ({inst[31:25], inst[14:12]})
                        10'h000: rec.result = a + b;
                        10'h100: rec.result = a - b;
                        10'h007: rec.result = a & b;
                        10'h006: rec.result = a | b;
                        10'h004: rec.result = a ^ b;
                        10'h002: rec.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: rec.wr_en  = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    case (inst[14:12])
                        3'b000:  rec.result = a + imm_i;
                        3'b111:  rec.result = a & imm_i;
                        3'b110:  rec.result = a | imm_i;
                        3'b100:  rec.result = a ^ imm_i;
                        default: rec.wr_en  = 1'b0;
                    endcase
                end
                7'b0110111: rec.result = {inst[31:12], 12'h000};
                7'b1100011: begin
                    rec.wr_en = 1'b0;
                    if (inst[14:12] == 3'b000) take = (a == b);
                    if (inst[14:12] == 3'b001) take = (a != b);
                end
                default: rec.wr_en = 1'b0;             // retires as a no-op
            endcase
            if (rec.rd_idx == '0) begin
                rec.wr_en = 1'b0;
            end
            if (rec.wr_en) begin
                x[rec.rd_idx] = rec.result;
            end
            expected.push_back(rec);
            pc = take ? pc + imm_b : pc + 32'd4;
            steps++;
        end
    endfunction

    ////////////////////////////////////////
    // compare and run
    ////////////////////////////////////////

    task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] want);
        $display("[FAIL] %s = %h, expected %h (test %0d, pc %h)", sig, got, want, cur_test,
                 commit.pc);
        test_errors++;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clock) begin
        ex_wb_t want;
        if (active && commit.valid) begin
            if ((commit.pc >> 2) >= cur_len) begin
                active    = 1'b0;                  // first fill word, program drained
                test_done = 1'b1;
            end else begin
                assert (expected.size() > 0) else begin
                    $display("test %0d: unexpected commit at pc %h", cur_test, commit.pc);
                    test_errors++;
                end
                if (expected.size() > 0) begin
                    want = expected.pop_front();
                    checked++;
                    assert (commit.pc == want.pc)
                        else value_error("commit.pc", commit.pc, want.pc);
                    assert (commit.wr_en == want.wr_en)
                        else value_error("commit.wr_en", 32'(commit.wr_en), 32'(want.wr_en));
                    if (want.wr_en) begin
                        assert (commit.rd_idx == want.rd_idx)
                            else value_error("commit.rd_idx", 32'(commit.rd_idx),
                                             32'(want.rd_idx));
                        assert (commit.result == want.result)
                            else value_error("commit.result", commit.result, want.result);
                    end
                end
            end
        end
    end

    task automatic run_test(input int t);
        @(posedge clock);
        #1;
        reset       = 1'b1;
        cur_test    = t;
        cur_base    = test_base[t];
        cur_len     = test_len[t];
        test_errors = 0;
        checked     = 0;
        model_program(cur_base, cur_len);
        repeat (8) @(posedge clock);
        #1;
        reset  = 1'b0;
        active = 1'b1;
        wait (test_done);
        test_done = 1'b0;
        assert (expected.size() == 0) else begin
            $display("test %0d: %0d expected commits never appeared", t, expected.size());
            test_errors++;
        end
        $display("test %0d %s: %0d commits checked, %0d errors", t, test_name[t], checked,
                 test_errors);
        error_count   += test_errors;
        total_checked += checked;
    endtask

    // run length bound, counted out of reset only
    always @(posedge clock) begin
        if (!reset) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("timeout: test %0d still running after %0d cycles", cur_test,
                         cycle_count);
                $display("** FAIL **");
                $finish;
            end
        end
    end

    initial begin
        reset = 1'b1;
        void'($urandom(32'h82bacb96));
        build_programs();
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycle_limit += test_len[t] + 10;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d commits checked, %0d errors, %0d assertion failures",
                 NUM_TESTS, total_checked, error_count, dut0.execute_stage0.chk0.assert_fails);
        if (error_count == 0 && dut0.execute_stage0.chk0.assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
